/* logic/axi_mon_pkg.sv */
/*
 * Shared definitions of the AXI4 monitor: field widths, channel payloads,
 * the violation flag set and the protocol limits
 */
package axi_mon_pkg;

    // The 64-bit data bus has eight byte lanes
    localparam int unsigned BusBytes = 8;
    // Largest legal AxSIZE on this bus, log2 of BusBytes
    localparam int unsigned MaxSize = 3;
    // A burst must stay inside one page of this many bytes
    localparam int unsigned PageBytes = 4096;
    localparam int unsigned AwQueueDepth = 8;
    // Read bursts the monitor tracks before the count saturates
    localparam int unsigned MaxOutstanding = 15;

    typedef logic [31:0] addr_t;
    typedef logic [3:0] id_t;
    // Number of beats minus one
    typedef logic [7:0] len_t;
    // Bytes per beat as a power of two
    typedef logic [2:0] size_t;
    typedef logic [1:0] burst_t;
    typedef logic [BusBytes-1:0] strb_t;
    // Index of one byte lane on the data bus
    typedef logic [$clog2(BusBytes)-1:0] lane_t;

    // Burst encodings as AXI4 defines them
    localparam burst_t BurstIncr = 2'd1;
    localparam burst_t BurstReserved = 2'd3;

    // Request fields shared by AW and AR
    typedef struct packed {
        addr_t  addr;
        id_t    id;
        len_t   len;
        size_t  size;
        burst_t burst;
    } axi_ax_t;

    // The data payload is not checked, so a W beat keeps only these
    typedef struct packed {
        strb_t strb;
        logic  last;
    } axi_w_t;

    // Used for both R and B, where a B beat always has last set
    typedef struct packed {
        id_t  id;
        logic last;
    } axi_resp_t;

    // One flag per protocol rule
    typedef struct packed {
        logic wlast_early;
        logic wlast_missing;
        logic strb_bad;
        logic w_without_aw;
        logic dup_id;
        logic cross_4k;
        logic size_too_big;
        logic burst_reserved;
        logic aw_overflow;
        logic r_without_ar;
        logic b_without_w;
        logic outstanding_overflow;
    } violation_t;

endpackage

/* logic/aw_queue.sv */
/*
 * Write-address queue: holds accepted AW requests until their last W beat,
 * with the incoming request bypassed to the head when the queue is empty
 */
`timescale 1ns/1ps

module aw_queue import axi_mon_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    aw_hsk_i,
    input  axi_ax_t aw_i,
    input  logic    w_last_hsk_i,
    output axi_ax_t head_o,
    output logic    head_valid_o,
    output logic    aw_overflow_o
);

    axi_ax_t mem_q [AwQueueDepth];
    logic [$clog2(AwQueueDepth)-1:0] wr_ptr_q;
    logic [$clog2(AwQueueDepth)-1:0] rd_ptr_q;
    logic [$clog2(AwQueueDepth+1)-1:0] count_q;
    logic empty;
    logic full;
    logic bypass;
    logic push;
    logic pop;

    // Pointers wrap explicitly so the depth need not be a power of two
    function automatic logic [$clog2(AwQueueDepth)-1:0] ptr_inc(
        input logic [$clog2(AwQueueDepth)-1:0] ptr
    );
        return (ptr == AwQueueDepth - 1) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count_q == '0);
    assign full  = (count_q == AwQueueDepth);

    // An empty queue shows the request on the bus as its head
    assign head_o       = empty ? aw_i : mem_q[rd_ptr_q];
    assign head_valid_o = !empty || aw_hsk_i;

    // A single-beat burst that arrives with its address never enters the queue
    assign bypass = empty && aw_hsk_i && w_last_hsk_i;
    assign pop    = w_last_hsk_i && !empty;
    // A full queue still accepts when its head leaves in the same cycle
    assign push   = aw_hsk_i && !bypass && (!full || pop);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            count_q       <= '0;
            aw_overflow_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // The dropped request is lost, later bursts then match the wrong head
            aw_overflow_o <= aw_hsk_i && full && !pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= aw_i;
        end
    end

endmodule

/* logic/w_beat_checker.sv */
/*
 * Write-data checker: counts the beats of the burst at the queue head,
 * checks WLAST against its length and the strobe lanes of INCR bursts
 */
`timescale 1ns/1ps

module w_beat_checker import axi_mon_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    w_valid_i,
    input  logic    w_ready_i,
    input  axi_w_t  w_i,
    input  axi_ax_t head_i,
    input  logic    head_valid_i,
    output logic    w_last_hsk_o,
    output logic    wlast_early_o,
    output logic    wlast_missing_o,
    output logic    strb_bad_o,
    output logic    w_without_aw_o
);

    logic  w_hsk;
    logic  first_beat;
    logic  strb_check;
    len_t  beat_cnt_q;
    lane_t lane_ptr_q;
    lane_t size_mask;
    lane_t addr_lane;
    lane_t lane_lo;
    lane_t lane_hi;
    strb_t exp_strb;

    assign w_hsk        = w_valid_i && w_ready_i;
    assign w_last_hsk_o = w_hsk && w_i.last;
    assign first_beat   = (beat_cnt_q == '0);

    // Lanes inside one container of 2**size bytes, e.g. 3'b011 for size 2
    assign size_mask = lane_t'((8'd1 << head_i.size) - 8'd1);
    assign addr_lane = head_i.addr[$bits(lane_t)-1:0];

    // Only INCR bursts of a legal size have their strobes checked
    assign strb_check = (head_i.burst == BurstIncr) && (head_i.size <= MaxSize);

    always_comb begin
        if (first_beat) begin
            // An unaligned start uses the lanes from its address to the container end
            lane_lo = addr_lane;
            lane_hi = addr_lane | size_mask;
        end else begin
            // Later beats fill their whole container
            lane_lo = lane_ptr_q;
            lane_hi = lane_ptr_q | size_mask;
        end
        for (int i = 0; i < BusBytes; i++) begin
            exp_strb[i] = (i >= lane_lo) && (i <= lane_hi);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beat_cnt_q      <= '0;
            lane_ptr_q      <= '0;
            wlast_early_o   <= 1'b0;
            wlast_missing_o <= 1'b0;
            strb_bad_o      <= 1'b0;
            w_without_aw_o  <= 1'b0;
        end else begin
            if (w_hsk) begin
                beat_cnt_q <= w_i.last ? '0 : beat_cnt_q + 1'b1;
                // Next container, wrapping around the bus width
                lane_ptr_q <= lane_hi + 1'b1;
            end

            wlast_early_o   <= w_hsk && head_valid_i && w_i.last
                               && (beat_cnt_q < head_i.len);
            wlast_missing_o <= w_hsk && head_valid_i && !w_i.last
                               && (beat_cnt_q == head_i.len);
            // Any extra or missing lane counts
            strb_bad_o      <= w_hsk && head_valid_i && strb_check
                               && (w_i.strb != exp_strb);

            // Valid alone is enough here, the slave may hold ready low
            w_without_aw_o  <= w_valid_i && !head_valid_i;
        end
    end

endmodule

/* logic/aw_rule_checker.sv */
/*
 * Write-address rule checker: page crossing, size, burst type
 * and reuse of an AWID whose burst is still open
 */
`timescale 1ns/1ps

module aw_rule_checker import axi_mon_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       aw_hsk_i,
    input  axi_ax_t    aw_i,
    input  logic       w_last_hsk_i,
    input  axi_ax_t    head_i,
    output violation_t viol_aw_o
);

    logic [2**$bits(id_t)-1:0] id_open_q;
    logic [31:0] page_off;
    logic [31:0] burst_bytes;
    violation_t viol_d;
    violation_t viol_q;

    // Burst footprint in bytes, wide enough for size 7 and 256 beats
    assign page_off    = aw_i.addr & 32'(PageBytes - 1);
    assign burst_bytes = (32'd1 << aw_i.size) * (32'(aw_i.len) + 32'd1);

    always_comb begin
        viol_d = '0;
        if (aw_hsk_i) begin
            viol_d.dup_id         = id_open_q[aw_i.id];
            viol_d.cross_4k       = (page_off + burst_bytes) > PageBytes;
            viol_d.size_too_big   = aw_i.size > MaxSize;
            viol_d.burst_reserved = aw_i.burst == BurstReserved;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_open_q <= '0;
            viol_q    <= '0;
        end else begin
            if (aw_hsk_i) begin
                id_open_q[aw_i.id] <= 1'b1;
            end
            // The clear comes last so a single-beat burst taken with its address
            // leaves its ID closed
            if (w_last_hsk_i) begin
                id_open_q[head_i.id] <= 1'b0;
            end
            viol_q <= viol_d;
        end
    end

    assign viol_aw_o = viol_q;

endmodule

/* logic/resp_order_checker.sv */
/*
 * Response order checker: flags R before its AR and B before
 * a finished write burst, and read requests beyond the tracked limit
 */
`timescale 1ns/1ps

module resp_order_checker import axi_mon_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      ar_hsk_i,
    input  logic      r_valid_i,
    input  logic      r_hsk_i,
    input  axi_resp_t r_i,
    input  logic      b_valid_i,
    input  logic      b_hsk_i,
    input  logic      w_last_hsk_i,
    output logic      r_without_ar_o,
    output logic      b_without_w_o,
    output logic      outstanding_overflow_o
);

    typedef logic [$clog2(MaxOutstanding+1)-1:0] cnt_t;

    cnt_t rd_cnt_q;
    cnt_t wr_cnt_q;

    // Saturates at both ends, an increment and a decrement together cancel
    function automatic cnt_t sat_step(input cnt_t cnt, input logic inc, input logic dec);
        cnt_t next;
        next = cnt;
        if (inc && !dec && (cnt != MaxOutstanding)) begin
            next = cnt + 1'b1;
        end
        if (dec && !inc && (cnt != '0)) begin
            next = cnt - 1'b1;
        end
        return next;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_cnt_q               <= '0;
            wr_cnt_q               <= '0;
            r_without_ar_o         <= 1'b0;
            b_without_w_o          <= 1'b0;
            outstanding_overflow_o <= 1'b0;
        end else begin
            // A read burst is done on its last R beat
            rd_cnt_q <= sat_step(rd_cnt_q, ar_hsk_i, r_hsk_i && r_i.last);
            wr_cnt_q <= sat_step(wr_cnt_q, w_last_hsk_i, b_hsk_i);

            r_without_ar_o         <= r_valid_i && (rd_cnt_q == '0);
            b_without_w_o          <= b_valid_i && (wr_cnt_q == '0);
            outstanding_overflow_o <= ar_hsk_i && (rd_cnt_q == MaxOutstanding);
        end
    end

endmodule

/* logic/axi_mon_top.sv */
/*
 * Passive AXI4 monitor: forms the channel handshakes, runs the rule checkers
 * and reports each violation as a pulse and as a sticky status
 */
`timescale 1ns/1ps

module axi_mon_top import axi_mon_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       aw_valid_i,
    input  logic       aw_ready_i,
    input  axi_ax_t    aw_i,
    input  logic       w_valid_i,
    input  logic       w_ready_i,
    input  axi_w_t     w_i,
    input  logic       b_valid_i,
    input  logic       b_ready_i,
    input  axi_resp_t  b_i,
    input  logic       ar_valid_i,
    input  logic       ar_ready_i,
    input  axi_ax_t    ar_i,
    input  logic       r_valid_i,
    input  logic       r_ready_i,
    input  axi_resp_t  r_i,
    output violation_t viol_o,
    output violation_t viol_seen_o
);

    logic aw_hsk, ar_hsk, r_hsk, b_hsk, w_last_hsk, w_pop, head_valid;
    axi_ax_t head;
    violation_t viol_aw, viol_rest, viol_seen_q;
    logic wlast_early, wlast_missing, strb_bad, w_without_aw, aw_overflow;
    logic r_without_ar, b_without_w, outstanding_overflow;

    // A beat is an event only in a cycle where valid meets ready
    assign aw_hsk = aw_valid_i && aw_ready_i;
    assign ar_hsk = ar_valid_i && ar_ready_i;
    assign r_hsk  = r_valid_i && r_ready_i;
    // B beats always carry last, so this is the plain handshake
    assign b_hsk  = b_valid_i && b_ready_i && b_i.last;
    // Only a burst that had an address closes an ID
    assign w_pop  = w_last_hsk && head_valid;

    aw_queue u_aw_queue (
        .clk_i, .rst_ni, .aw_hsk_i(aw_hsk), .aw_i, .w_last_hsk_i(w_last_hsk),
        .head_o(head), .head_valid_o(head_valid), .aw_overflow_o(aw_overflow)
    );

    w_beat_checker u_w_beat_checker (
        .clk_i, .rst_ni, .w_valid_i, .w_ready_i, .w_i, .head_i(head),
        .head_valid_i(head_valid), .w_last_hsk_o(w_last_hsk), .wlast_early_o(wlast_early),
        .wlast_missing_o(wlast_missing), .strb_bad_o(strb_bad), .w_without_aw_o(w_without_aw)
    );

    aw_rule_checker u_aw_rule_checker (
        .clk_i, .rst_ni, .aw_hsk_i(aw_hsk), .aw_i, .w_last_hsk_i(w_pop),
        .head_i(head), .viol_aw_o(viol_aw)
    );

    // AR payload carries nothing the read ordering rule needs
    resp_order_checker u_resp_order_checker (
        .clk_i, .rst_ni, .ar_hsk_i(ar_hsk), .r_valid_i, .r_hsk_i(r_hsk), .r_i,
        .b_valid_i, .b_hsk_i(b_hsk), .w_last_hsk_i(w_last_hsk),
        .r_without_ar_o(r_without_ar), .b_without_w_o(b_without_w),
        .outstanding_overflow_o(outstanding_overflow)
    );

    // All parts are registered in their checkers, so this OR keeps the one-cycle timing
    always_comb begin
        viol_rest                      = '0;
        viol_rest.wlast_early          = wlast_early;
        viol_rest.wlast_missing        = wlast_missing;
        viol_rest.strb_bad             = strb_bad;
        viol_rest.w_without_aw         = w_without_aw;
        viol_rest.aw_overflow          = aw_overflow;
        viol_rest.r_without_ar         = r_without_ar;
        viol_rest.b_without_w          = b_without_w;
        viol_rest.outstanding_overflow = outstanding_overflow;
    end

    assign viol_o = violation_t'(viol_rest | viol_aw);

    // Sticky copy, cleared only by reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            viol_seen_q <= '0;
        end else begin
            viol_seen_q <= viol_seen_q | viol_o;
        end
    end

    assign viol_seen_o = viol_seen_q;

endmodule

/* dv/axi_mon_sva.sv */
/*
 * Assertions on the monitor outputs: the sticky status never drops a bit,
 * reset silences the pulses, and every pulse reaches the sticky status
 */
`timescale 1ns/1ps

module axi_mon_sva import axi_mon_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input violation_t viol_o,
    input violation_t viol_seen_o
);

    // A sticky bit may only be cleared by reset
    sticky_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (($past(viol_seen_o) & ~viol_seen_o) == '0))
        else $error("viol_seen_o lost a bit outside reset");

    reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> (viol_o == '0))
        else $error("viol_o is not zero during reset");

    // Each pulse is folded into the sticky status on the next edge
    pulse_recorded: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (viol_o != '0) |=> ((viol_seen_o & $past(viol_o)) == $past(viol_o)))
        else $error("a viol_o bit did not reach viol_seen_o");

endmodule

bind axi_mon_top axi_mon_sva u_sva (.clk_i, .rst_ni, .viol_o, .viol_seen_o);

/* dv/axi_mon_tb.sv */
/*
 * Testbench of the AXI4 monitor: random legal and faulty traffic from an LFSR,
 * a cycle model of every rule and a compare of viol_o and viol_seen_o
 */
`timescale 1ns/1ps

module axi_mon_tb import axi_mon_pkg::*; ();

    localparam logic [15:0] LfsrSeed = 16'd87;
    localparam logic [15:0] LfsrTaps = 16'hB400;
    localparam int WaitLimit = 32;
    localparam int ChAw = 0;
    localparam int ChW = 1;
    localparam int ChB = 2;
    localparam int ChAr = 3;
    localparam int ChR = 4;

    logic clk_i, rst_ni;
    logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_valid, r_ready;
    axi_ax_t aw_pl, ar_pl;
    axi_w_t w_pl;
    axi_resp_t b_pl, r_pl;
    violation_t viol_o, viol_seen_o;

    logic [15:0] lfsr_q;
    // Model state
    axi_ax_t mq[$];
    len_t bcnt;
    logic [15:0] open_ids;
    int unsigned rd_cnt, wr_cnt;
    violation_t prev_exp, seen_exp, test_seen;
    int errors, checks, err_mark, tests_run, tests_failed;

    axi_mon_top dut_i (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .aw_valid_i(aw_valid), .aw_ready_i(aw_ready), .aw_i(aw_pl),
        .w_valid_i(w_valid), .w_ready_i(w_ready), .w_i(w_pl),
        .b_valid_i(b_valid), .b_ready_i(b_ready), .b_i(b_pl),
        .ar_valid_i(ar_valid), .ar_ready_i(ar_ready), .ar_i(ar_pl),
        .r_valid_i(r_valid), .r_ready_i(r_ready), .r_i(r_pl),
        .viol_o(viol_o), .viol_seen_o(viol_seen_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Galois LFSR stepped once per random bit
    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ LfsrTaps;
        end
        return b;
    endfunction

    function automatic int unsigned next_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | next_bit();
        end
        return v;
    endfunction

    // Legal INCR request that stays in the lower half of its page
    function automatic axi_ax_t random_aw();
        axi_ax_t ax;
        ax.addr = {12'h0, 8'(next_bits(8)), 1'b0, 11'(next_bits(11))};
        ax.id = id_t'(next_bits(4));
        ax.len = len_t'(next_bits(3));
        ax.size = size_t'(next_bits(2));
        ax.burst = BurstIncr;
        if (next_bit()) begin
            ax.addr[2:0] = 3'd0;
        end
        return ax;
    endfunction

    // Byte lanes of beat n of an INCR burst as the AXI address rules give them
    function automatic strb_t lanes_of_beat(input axi_ax_t ax, input int unsigned n);
        int unsigned nbytes, cont, first, last;
        strb_t s;
        nbytes = 1 << ax.size;
        cont = (int'(ax.addr[2:0]) / nbytes) * nbytes;
        // The container of beat n wraps around the bus width
        first = (cont + n * nbytes) % BusBytes;
        last = first + nbytes - 1;
        if (n == 0) begin
            first = int'(ax.addr[2:0]);
        end
        for (int i = 0; i < BusBytes; i++) begin
            s[i] = (i >= first) && (i <= last);
        end
        return s;
    endfunction

    // Predicts the pulses of one sampled edge and advances the model
    task automatic model_cycle(output violation_t exp);
        logic aw_h, w_h, wl_h, ar_h, r_h, b_h, hv, pop, push, byp;
        axi_ax_t hd;
        int unsigned page_off;
        exp = '0;
        if (!rst_ni) begin
            mq.delete();
            bcnt = '0;
            open_ids = '0;
            rd_cnt = 0;
            wr_cnt = 0;
            prev_exp = '0;
            seen_exp = '0;
            return;
        end
        seen_exp = seen_exp | prev_exp;
        aw_h = aw_valid && aw_ready;
        w_h = w_valid && w_ready;
        wl_h = w_h && w_pl.last;
        ar_h = ar_valid && ar_ready;
        r_h = r_valid && r_ready;
        b_h = b_valid && b_ready;
        hv = (mq.size() != 0) || aw_h;
        hd = (mq.size() != 0) ? mq[0] : aw_pl;

        if (w_h && hv) begin
            exp.wlast_early = w_pl.last && (bcnt < hd.len);
            exp.wlast_missing = !w_pl.last && (bcnt == hd.len);
            exp.strb_bad = (hd.burst == BurstIncr) && (hd.size <= MaxSize)
                           && (w_pl.strb != lanes_of_beat(hd, int'(bcnt)));
        end
        exp.w_without_aw = w_valid && !hv;
        if (aw_h) begin
            page_off = aw_pl.addr % PageBytes;
            exp.dup_id = open_ids[aw_pl.id];
            exp.cross_4k = (page_off + (1 << aw_pl.size) * (int'(aw_pl.len) + 1)) > PageBytes;
            exp.size_too_big = aw_pl.size > MaxSize;
            exp.burst_reserved = aw_pl.burst == BurstReserved;
        end
        exp.aw_overflow = aw_h && (mq.size() == AwQueueDepth) && !wl_h;
        exp.r_without_ar = r_valid && (rd_cnt == 0);
        exp.b_without_w = b_valid && (wr_cnt == 0);
        exp.outstanding_overflow = ar_h && (rd_cnt == MaxOutstanding);

        if (w_h) begin
            bcnt = wl_h ? '0 : bcnt + 1'b1;
        end
        if (aw_h) begin
            open_ids[aw_pl.id] = 1'b1;
        end
        // A finished burst closes its ID even when it was opened in this cycle
        if (wl_h && hv) begin
            open_ids[hd.id] = 1'b0;
        end
        pop = wl_h && (mq.size() != 0);
        byp = (mq.size() == 0) && aw_h && wl_h;
        push = aw_h && !byp && ((mq.size() < AwQueueDepth) || pop);
        if (pop) begin
            void'(mq.pop_front());
        end
        if (push) begin
            mq.push_back(aw_pl);
        end
        if (ar_h && !(r_h && r_pl.last) && (rd_cnt != MaxOutstanding)) begin
            rd_cnt++;
        end else if (!ar_h && r_h && r_pl.last && (rd_cnt != 0)) begin
            rd_cnt--;
        end
        if (wl_h && !b_h) begin
            wr_cnt = (wr_cnt == MaxOutstanding) ? wr_cnt : wr_cnt + 1;
        end else if (!wl_h && b_h && (wr_cnt != 0)) begin
            wr_cnt--;
        end
        prev_exp = exp;
        test_seen = test_seen | exp;
    endtask

    // One clock with the model run at the edge and the compare 1 ns later,
    // returning at the drive point
    task automatic step();
        violation_t exp;
        @(posedge clk_i);
        model_cycle(exp);
        #1;
        checks++;
        if (viol_o !== exp) begin
            errors++;
            $display("CHECK FAILED t=%0t viol_o exp=%h got=%h", $time, exp, viol_o);
        end
        if (viol_seen_o !== seen_exp) begin
            errors++;
            $display("CHECK FAILED t=%0t viol_seen_o exp=%h got=%h",
                     $time, seen_exp, viol_seen_o);
        end
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("Timeout, %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic set_ready(input int ch, input logic v);
        case (ch)
            ChAw: aw_ready = v;
            ChW: w_ready = v;
            ChB: b_ready = v;
            ChAr: ar_ready = v;
            default: r_ready = v;
        endcase
    endtask

    // Holds the beat on channel ch until the random slave takes it
    task automatic accept(input int ch);
        logic rdy;
        int tries;
        rdy = 1'b0;
        tries = 0;
        while (!rdy) begin
            if (tries == WaitLimit) begin
                abort_run("no handshake within the wait limit");
            end
            // Stalls are random but never longer than three cycles
            rdy = next_bit() || (tries >= 3);
            set_ready(ch, rdy);
            step();
            tries++;
        end
        set_ready(ch, 1'b0);
    endtask

    task automatic send_aw(input axi_ax_t ax);
        aw_valid = 1'b1;
        aw_pl = ax;
        accept(ChAw);
        aw_valid = 1'b0;
    endtask

    task automatic send_ar(input axi_ax_t ax);
        ar_valid = 1'b1;
        ar_pl = ax;
        accept(ChAr);
        ar_valid = 1'b0;
    endtask

    task automatic send_b(input id_t id);
        b_valid = 1'b1;
        b_pl = '{id: id, last: 1'b1};
        accept(ChB);
        b_valid = 1'b0;
    endtask

    task automatic send_w(input strb_t strb, input logic last);
        w_valid = 1'b1;
        w_pl = '{strb: strb, last: last};
        accept(ChW);
        w_valid = 1'b0;
    endtask

    // Fault 0 none, 1 early last, 2 missing last, 3 bad first strobe, 4 bad later strobe
    task automatic write_burst(input axi_ax_t ax, input int fault);
        logic together, last;
        strb_t strb;
        int unsigned n;
        together = next_bit();
        if (!together) begin
            send_aw(ax);
        end
        n = 0;
        last = 1'b0;
        while (!last) begin
            last = (n == ax.len);
            if (fault == 1) begin
                last = (n + 1 == ax.len);
            end else if (fault == 2) begin
                last = (n == ax.len + 1);
            end
            strb = lanes_of_beat(ax, n);
            if ((fault == 3 && n == 0) || (fault == 4 && n == 1)) begin
                strb = strb ^ strb_t'(1 << next_bits(3));
            end
            if (together && n == 0) begin
                // Address and first beat in one cycle exercise the queue bypass
                aw_valid = 1'b1;
                aw_ready = 1'b1;
                aw_pl = ax;
                w_valid = 1'b1;
                w_ready = 1'b1;
                w_pl = '{strb: strb, last: last};
                step();
                {aw_valid, aw_ready, w_valid, w_ready} = 4'b0;
            end else begin
                send_w(strb, last);
            end
            n++;
        end
        send_b(ax.id);
    endtask

    task automatic read_burst(input axi_ax_t ax);
        send_ar(ax);
        for (int n = 0; n <= ax.len; n++) begin
            r_valid = 1'b1;
            r_pl = '{id: ax.id, last: (n == ax.len)};
            accept(ChR);
        end
        r_valid = 1'b0;
    endtask

    task automatic reset_dut();
        {aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready} = 6'b0;
        {ar_valid, ar_ready, r_valid, r_ready} = 4'b0;
        aw_pl = '0;
        ar_pl = '0;
        w_pl = '0;
        b_pl = '0;
        r_pl = '0;
        rst_ni = 1'b0;
        step();
        step();
        rst_ni = 1'b1;
        err_mark = errors;
        test_seen = '0;
    endtask

    // A test passes with no mismatches and every wanted flag predicted
    task automatic finish_test(input string name, input violation_t want);
        logic ok;
        repeat (2) step();
        ok = (errors == err_mark);
        if ((want == '0) && (test_seen != '0)) begin
            $display("Legal traffic in test %s raised a violation", name);
            ok = 1'b0;
        end
        if ((test_seen & want) != want) begin
            $display("Stimulus in test %s missed an expected violation", name);
            ok = 1'b0;
        end
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test %-8s %s", name, ok ? "passed" : "failed");
    endtask

    initial begin
        violation_t want;
        lfsr_q = LfsrSeed;
        {errors, checks, tests_run, tests_failed} = '0;
        rst_ni = 1'b0;

        reset_dut();
        for (int i = 0; i < 12; i++) begin
            write_burst(random_aw(), 0);
            if (next_bit()) begin
                read_burst(random_aw());
            end
        end
        finish_test("legal", '0);

        reset_dut();
        for (int i = 0; i < 4; i++) begin
            axi_ax_t ax;
            ax = random_aw();
            ax.len[0] = 1'b1;
            write_burst(ax, 1 + (i % 2));
        end
        want = '0;
        want.wlast_early = 1'b1;
        want.wlast_missing = 1'b1;
        finish_test("wlast", want);

        reset_dut();
        for (int i = 0; i < 4; i++) begin
            axi_ax_t ax;
            ax = random_aw();
            ax.len[0] = 1'b1;
            write_burst(ax, 3 + (i % 2));
        end
        send_w(8'hFF, 1'b1);
        want = '0;
        want.strb_bad = 1'b1;
        want.w_without_aw = 1'b1;
        finish_test("strobe", want);

        reset_dut();
        send_aw('{addr: 32'h100, id: 4'd5, len: 8'd0, size: 3'd2, burst: BurstIncr});
        send_aw('{addr: 32'h200, id: 4'd5, len: 8'd0, size: 3'd2, burst: BurstIncr});
        send_aw('{addr: 32'hFF8, id: 4'd1, len: 8'd1, size: 3'd3, burst: BurstIncr});
        send_aw('{addr: 32'h2000, id: 4'd2, len: 8'd0, size: 3'd4, burst: BurstIncr});
        send_aw('{addr: 32'h3000, id: 4'd3, len: 8'd0, size: 3'd2, burst: BurstReserved});
        // Four more fill the queue and the last of them is dropped
        for (int i = 6; i < 10; i++) begin
            send_aw('{addr: 32'h4000, id: id_t'(i), len: 8'd0, size: 3'd2, burst: BurstIncr});
        end
        want = '0;
        want.dup_id = 1'b1;
        want.cross_4k = 1'b1;
        want.size_too_big = 1'b1;
        want.burst_reserved = 1'b1;
        want.aw_overflow = 1'b1;
        finish_test("aw_rules", want);

        reset_dut();
        r_valid = 1'b1;
        r_pl = '{id: 4'd0, last: 1'b1};
        accept(ChR);
        r_valid = 1'b0;
        send_b(4'd0);
        for (int i = 0; i < 16; i++) begin
            send_ar(random_aw());
        end
        want = '0;
        want.r_without_ar = 1'b1;
        want.b_without_w = 1'b1;
        want.outstanding_overflow = 1'b1;
        finish_test("order", want);

        $display("tests %0d, failed %0d, checks %0d, mismatches %0d",
                 tests_run, tests_failed, checks, errors);
        if ((tests_failed == 0) && (errors == 0)) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
logic/axi_mon_pkg.sv
logic/aw_queue.sv
logic/w_beat_checker.sv
logic/aw_rule_checker.sv
logic/resp_order_checker.sv
logic/axi_mon_top.sv
dv/axi_mon_sva.sv
dv/axi_mon_tb.sv
